// File: hw/bank_cfg.svh
// Sizing macros for the write-response bank
// Identifier count, slot capacity and the widths derived from them

`ifndef BANK_CFG_SVH
`define BANK_CFG_SVH

//////////////////////////////
// Identifiers
//////////////////////////////

// Number of AXI write identifiers tracked by the bank
`define BANK_NUM_IDS 4
// Bits needed to carry one identifier
`define BANK_ID_W 2

//////////////////////////////
// Slot array
//////////////////////////////

// Total slots shared by all identifiers
`define BANK_CAPACITY 8
// Bits of a slot address
`define BANK_ADDR_W 3
// Response content without the identifier, the AXI resp code
`define BANK_PAYLOAD_W 2

`endif

// File: hw/resp_pkg.sv
// AXI write-response message types
// Identifier, payload and the combined response word seen at the bank ports

`default_nettype none

`include "bank_cfg.svh"

package resp_pkg;

  // AXI write identifier
  typedef logic [`BANK_ID_W-1:0] axi_id_t;

  // Response content, carries the BRESP code
  typedef logic [`BANK_PAYLOAD_W-1:0] wresp_payload_t;

  // Full response as it enters and leaves the bank
  typedef struct packed {
    axi_id_t        id;
    wresp_payload_t payload;
  } wresp_t;

endpackage

`default_nettype wire

// File: hw/bank_pkg.sv
// Bookkeeping types shared between the bank submodules
// Slot address, per-identifier queue status, link write and slot free strobe

`default_nettype none

`include "bank_cfg.svh"

package bank_pkg;

  // Address of one slot in the shared array
  typedef logic [`BANK_ADDR_W-1:0] slot_addr_t;

  // Queue state published by each id_queue
  typedef struct packed {
    slot_addr_t fill_addr;    // Slot the next input lands in
    slot_addr_t tail_addr;    // Oldest filled slot
    logic       rsv_pending;  // Reserved slots still waiting for data
    logic       msg_pending;  // Filled slots not yet released
  } queue_status_t;

  // Next-link update for the slot array
  typedef struct packed {
    logic       en;
    slot_addr_t addr;  // Slot whose link changes
    slot_addr_t nxt;   // Slot that now follows it
  } link_wr_t;

  // Slot recycling strobe after the output handshake
  typedef struct packed {
    logic       en;
    slot_addr_t addr;
  } slot_free_t;

endpackage

`default_nettype wire

// File: hw/slot_alloc.sv
// Slot allocator
// Occupancy bits, lowest free slot search and the reservation handshake

`timescale 1ns/1ps
`default_nettype none

`include "bank_cfg.svh"

module slot_alloc import bank_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     i_rsv_valid,
  input  logic [`BANK_NUM_IDS-1:0] i_rsv_id_onehot,
  input  slot_free_t               i_free,
  output logic                     o_rsv_ready,
  output slot_addr_t               o_rsv_addr,
  output logic [`BANK_NUM_IDS-1:0] o_rsv_grant
);

  logic [`BANK_CAPACITY-1:0] occ_q;
  logic [`BANK_CAPACITY-1:0] occ_d;
  logic                      rsv_fire;

  // Any clear bit means a slot can be handed out
  assign o_rsv_ready = ~&occ_q;
  assign rsv_fire    = i_rsv_valid & o_rsv_ready;

  // Lowest clear bit wins, scan from the top so the last hit is the smallest
  always_comb begin
    o_rsv_addr = '0;
    for (int i = `BANK_CAPACITY - 1; i >= 0; i--) begin
      if (!occ_q[i]) begin
        o_rsv_addr = slot_addr_t'(i);
      end
    end
  end

  // Only the requesting identifier sees the strobe
  assign o_rsv_grant = i_rsv_id_onehot & {`BANK_NUM_IDS{rsv_fire}};

  // Reserved and freed slots never coincide, the freed one is occupied
  always_comb begin
    occ_d = occ_q;
    if (rsv_fire) begin
      occ_d[o_rsv_addr] = 1'b1;
    end
    if (i_free.en) begin
      occ_d[i_free.addr] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_q <= '0;
    end else begin
      occ_q <= occ_d;
    end
  end

  // Released slot must have been in use, a reservation names exactly one identifier
  a_free_occupied: assert property (@(posedge clk_i) disable iff (!rst_ni)
    i_free.en |-> occ_q[i_free.addr]);
  a_rsv_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsv_fire |-> $onehot(i_rsv_id_onehot));

endmodule

`default_nettype wire

// File: hw/id_queue.sv
// Per-identifier linked list of slots
// Reservation head, fill pointer, tail and the reserved and filled counters

`timescale 1ns/1ps
`default_nettype none

`include "bank_cfg.svh"

module id_queue import bank_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          i_grant,
  input  logic          i_fill,
  input  logic          i_pop,
  input  slot_addr_t    i_free_addr,
  input  slot_addr_t    i_fill_link,
  input  slot_addr_t    i_tail_link,
  output queue_status_t o_status,
  output link_wr_t      o_link_wr
);

  // Counters must reach the full capacity
  localparam int unsigned CNT_W = `BANK_ADDR_W + 1;

  slot_addr_t       head_q, head_d;
  slot_addr_t       fill_q, fill_d;
  slot_addr_t       tail_q, tail_d;
  logic [CNT_W-1:0] rsv_cnt_q, rsv_cnt_d;
  logic [CNT_W-1:0] msg_cnt_q, msg_cnt_d;
  logic             list_live;
  logic             msg_drained;
  slot_addr_t       fill_nxt;
  slot_addr_t       tail_nxt;

  //////////////////////////////
  // Links
  //////////////////////////////

  assign list_live = (rsv_cnt_q != '0) || (msg_cnt_q != '0);

  // Chain the new slot behind the current head when the list is live
  assign o_link_wr.en   = i_grant & list_live;
  assign o_link_wr.addr = head_q;
  assign o_link_wr.nxt  = i_free_addr;

  // A link written this cycle is not in the array yet, take it straight
  assign fill_nxt = (o_link_wr.en && o_link_wr.addr == fill_q) ? i_free_addr : i_fill_link;
  assign tail_nxt = (o_link_wr.en && o_link_wr.addr == tail_q) ? i_free_addr : i_tail_link;

  // No filled message left once this cycle's pop is done
  assign msg_drained = (msg_cnt_q == '0) || (msg_cnt_q == CNT_W'(1) && i_pop);

  //////////////////////////////
  // Pointer update
  //////////////////////////////

  always_comb begin
    head_d    = head_q;
    fill_d    = fill_q;
    tail_d    = tail_q;
    rsv_cnt_d = rsv_cnt_q + CNT_W'(i_grant) - CNT_W'(i_fill);
    msg_cnt_d = msg_cnt_q + CNT_W'(i_fill) - CNT_W'(i_pop);

    if (i_grant) begin
      head_d = i_free_addr;
      // Fresh list, all pointers start at the granted slot
      if (!list_live) begin
        tail_d = i_free_addr;
      end
      // Nothing reserved ahead, the new slot is the next to fill
      if (rsv_cnt_q == '0) begin
        fill_d = i_free_addr;
      end
    end

    // Oldest reserved slot filled, step to its follower
    if (i_fill) begin
      fill_d = fill_nxt;
    end

    if (i_pop) begin
      tail_d = tail_nxt;
    end
    // The slot just filled becomes the oldest when nothing else waits
    if (i_fill && msg_drained) begin
      tail_d = fill_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q    <= '0;
      fill_q    <= '0;
      tail_q    <= '0;
      rsv_cnt_q <= '0;
      msg_cnt_q <= '0;
    end else begin
      head_q    <= head_d;
      fill_q    <= fill_d;
      tail_q    <= tail_d;
      rsv_cnt_q <= rsv_cnt_d;
      msg_cnt_q <= msg_cnt_d;
    end
  end

  assign o_status.fill_addr   = fill_q;
  assign o_status.tail_addr   = tail_q;
  assign o_status.rsv_pending = rsv_cnt_q != '0;
  assign o_status.msg_pending = msg_cnt_q != '0;

  // Store and arbiter only act on queues that hold something
  a_pop_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    i_pop |-> o_status.msg_pending);
  a_fill_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    i_fill |-> o_status.rsv_pending);

endmodule

`default_nettype wire

// File: hw/msg_store.sv
// Slot storage
// Payload and next-link arrays, input acceptance and link read ports

`timescale 1ns/1ps
`default_nettype none

`include "bank_cfg.svh"

module msg_store import resp_pkg::*; import bank_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     i_in_valid,
  input  wresp_t                   i_in_data,
  input  queue_status_t            i_status [`BANK_NUM_IDS],
  input  link_wr_t                 i_link_wr [`BANK_NUM_IDS],
  input  slot_addr_t               i_rd_addr,
  output logic                     o_in_ready,
  output logic [`BANK_NUM_IDS-1:0] o_fill,
  output slot_addr_t               o_fill_link [`BANK_NUM_IDS],
  output slot_addr_t               o_tail_link [`BANK_NUM_IDS],
  output wresp_payload_t           o_payload
);

  wresp_payload_t             pay_q  [`BANK_CAPACITY];
  slot_addr_t                 link_q [`BANK_CAPACITY];
  logic                       in_fire;
  link_wr_t                   link_sel;
  logic [`BANK_NUM_IDS-1:0]   link_en;

  // Accept only when this identifier has a slot waiting, ready follows valid
  assign o_in_ready = i_in_valid & i_status[i_in_data.id].rsv_pending;
  assign in_fire    = i_in_valid & o_in_ready;

  always_comb begin
    o_fill = '0;
    o_fill[i_in_data.id] = in_fire;
  end

  // Pick the one queue that extends its list this cycle
  always_comb begin
    link_sel = '0;
    for (int i = 0; i < `BANK_NUM_IDS; i++) begin
      link_en[i] = i_link_wr[i].en;
      if (i_link_wr[i].en) begin
        link_sel = i_link_wr[i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_fire) begin
      pay_q[i_status[i_in_data.id].fill_addr] <= i_in_data.payload;
    end
    if (link_sel.en) begin
      link_q[link_sel.addr] <= link_sel.nxt;
    end
  end

  // Followers of each queue's fill and tail slots
  for (genvar g = 0; g < `BANK_NUM_IDS; g++) begin : g_link_rd
    assign o_fill_link[g] = link_q[i_status[g].fill_addr];
    assign o_tail_link[g] = link_q[i_status[g].tail_addr];
  end

  assign o_payload = pay_q[i_rd_addr];

  // Grants are one-hot, so only one list grows per cycle
  a_one_link: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(link_en));

endmodule

`default_nettype wire

// File: hw/release_arb.sv
// Release arbiter
// Lowest-identifier pick among enabled tails, output register and free strobe

`timescale 1ns/1ps
`default_nettype none

`include "bank_cfg.svh"

module release_arb import resp_pkg::*; import bank_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  queue_status_t            i_status [`BANK_NUM_IDS],
  input  logic [`BANK_CAPACITY-1:0] i_release_en,
  input  wresp_payload_t           i_payload,
  input  logic                     i_out_ready,
  output logic [`BANK_NUM_IDS-1:0] o_pop,
  output slot_addr_t               o_rd_addr,
  output slot_free_t               o_free,
  output logic                     o_out_valid,
  output wresp_t                   o_out_data
);

  logic [`BANK_NUM_IDS-1:0] eligible;
  logic [`BANK_NUM_IDS-1:0] pick;
  logic                     load;
  logic                     out_fire;
  logic                     valid_q;
  axi_id_t                  id_q;
  slot_addr_t               addr_q;
  axi_id_t                  sel_id;
  slot_addr_t               sel_addr;

  //////////////////////////////
  // Selection
  //////////////////////////////

  // Queue competes when its oldest message has its slot enabled
  for (genvar g = 0; g < `BANK_NUM_IDS; g++) begin : g_elig
    assign eligible[g] = i_status[g].msg_pending & i_release_en[i_status[g].tail_addr];
  end

  // Isolate the lowest set bit
  assign pick = eligible & ~(eligible - 1'b1);

  assign out_fire = valid_q & i_out_ready;
  // Register free or draining this cycle
  assign load     = ~valid_q | i_out_ready;
  assign o_pop    = pick & {`BANK_NUM_IDS{load}};

  always_comb begin
    sel_id   = '0;
    sel_addr = '0;
    for (int i = 0; i < `BANK_NUM_IDS; i++) begin
      if (pick[i]) begin
        sel_id   = axi_id_t'(i);
        sel_addr = i_status[i].tail_addr;
      end
    end
  end

  //////////////////////////////
  // Output register
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= |pick;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      id_q   <= sel_id;
      addr_q <= sel_addr;
    end
  end

  assign o_rd_addr          = addr_q;
  assign o_out_valid        = valid_q;
  assign o_out_data.id      = id_q;
  assign o_out_data.payload = i_payload;

  // Slot goes back to the allocator on the handshake
  assign o_free.en   = out_fire;
  assign o_free.addr = addr_q;

  // Stalled response holds, payload included
  a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_out_data));

endmodule

`default_nettype wire

// File: hw/resp_bank.sv
// Write-response bank top
// Allocator, per-identifier queues, slot storage and release arbiter

`timescale 1ns/1ps
`default_nettype none

`include "bank_cfg.svh"

module resp_bank import resp_pkg::*; import bank_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      i_rsv_valid,
  input  logic [`BANK_NUM_IDS-1:0]  i_rsv_id_onehot,
  output logic                      o_rsv_ready,
  output slot_addr_t                o_rsv_addr,
  input  logic                      i_in_valid,
  input  wresp_t                    i_in_data,
  output logic                      o_in_ready,
  input  logic [`BANK_CAPACITY-1:0] i_release_en,
  input  logic                      i_out_ready,
  output logic                      o_out_valid,
  output wresp_t                    o_out_data
);

  logic [`BANK_NUM_IDS-1:0] grant;
  logic [`BANK_NUM_IDS-1:0] fill;
  logic [`BANK_NUM_IDS-1:0] pop;
  queue_status_t            status    [`BANK_NUM_IDS];
  link_wr_t                 link_wr   [`BANK_NUM_IDS];
  slot_addr_t               fill_link [`BANK_NUM_IDS];
  slot_addr_t               tail_link [`BANK_NUM_IDS];
  slot_addr_t               rd_addr;
  wresp_payload_t           payload;
  slot_free_t               slot_free;

  slot_alloc u_alloc (
    .clk_i, .rst_ni, .i_rsv_valid, .i_rsv_id_onehot,
    .i_free      (slot_free),
    .o_rsv_ready,
    .o_rsv_addr,
    .o_rsv_grant (grant)
  );

  // One linked list per identifier
  for (genvar g = 0; g < `BANK_NUM_IDS; g++) begin : g_queue
    id_queue u_queue (
      .clk_i, .rst_ni,
      .i_grant     (grant[g]),
      .i_fill      (fill[g]),
      .i_pop       (pop[g]),
      .i_free_addr (o_rsv_addr),
      .i_fill_link (fill_link[g]),
      .i_tail_link (tail_link[g]),
      .o_status    (status[g]),
      .o_link_wr   (link_wr[g])
    );
  end

  msg_store u_store (
    .clk_i, .rst_ni, .i_in_valid, .i_in_data,
    .i_status    (status),
    .i_link_wr   (link_wr),
    .i_rd_addr   (rd_addr),
    .o_in_ready,
    .o_fill      (fill),
    .o_fill_link (fill_link),
    .o_tail_link (tail_link),
    .o_payload   (payload)
  );

  release_arb u_arb (
    .clk_i, .rst_ni,
    .i_status    (status),
    .i_release_en,
    .i_payload   (payload),
    .i_out_ready,
    .o_pop       (pop),
    .o_rd_addr   (rd_addr),
    .o_free      (slot_free),
    .o_out_valid,
    .o_out_data
  );

endmodule

`default_nettype wire

// File: bench/resp_bank_tests.svh
// Directed tests for the write-response bank
// Handshake helpers that keep the model in step, then one task per behavior

`ifndef RESP_BANK_TESTS_SVH
`define RESP_BANK_TESTS_SVH

// Cycles a single handshake may take before it counts as hung
localparam int WAIT_LIMIT = 64;

//////////////////////////////
// Helpers
//////////////////////////////

task automatic check_val(input string name, input int got, input int exp);
  checks++;
  if (got != exp) begin
    errors++;
    $display("[FAIL] %0t ns %s got %0h expected %0h", $time, name, got, exp);
  end
endtask

task automatic report_timeout(input string what);
  errors++;
  $display("Timeout: no %s within %0d cycles at %0t ns", what, WAIT_LIMIT, $time);
endtask

// First slot nobody holds, per the model
function automatic int lowest_free();
  for (int i = 0; i < `BANK_CAPACITY; i++) begin
    if (!occ_model[i]) begin
      return i;
    end
  end
  return `BANK_CAPACITY;
endfunction

// Oldest entry of an id, optionally only among the unfilled ones
function automatic int oldest(input axi_id_t id, input bit unfilled);
  for (int i = 0; i < pend.size(); i++) begin
    if (pend[i].id == id && !(unfilled && pend[i].filled)) begin
      return i;
    end
  end
  return -1;
endfunction

task automatic reserve(input axi_id_t id, output slot_addr_t slot);
  int     n;
  entry_t e;
  n    = 0;
  slot = '0;
  i_rsv_valid         = 1'b1;
  i_rsv_id_onehot     = '0;
  i_rsv_id_onehot[id] = 1'b1;
  #1;
  while (!o_rsv_ready && n < WAIT_LIMIT) begin
    @(negedge clk_i);
    #1;
    n++;
  end
  if (!o_rsv_ready) begin
    report_timeout("o_rsv_ready");
  end else begin
    check_val("o_rsv_addr", int'(o_rsv_addr), lowest_free());
    slot      = o_rsv_addr;
    e.id      = id;
    e.slot    = o_rsv_addr;
    e.filled  = 1'b0;
    e.payload = '0;
    pend.push_back(e);
    occ_model[o_rsv_addr] = 1'b1;
  end
  @(negedge clk_i);
  i_rsv_valid     = 1'b0;
  i_rsv_id_onehot = '0;
endtask

// Fill the oldest open slot of the id
task automatic send_resp(input axi_id_t id, input wresp_payload_t payload);
  int     n;
  int     k;
  entry_t e;
  n = 0;
  i_in_valid        = 1'b1;
  i_in_data.id      = id;
  i_in_data.payload = payload;
  #1;
  while (!o_in_ready && n < WAIT_LIMIT) begin
    @(negedge clk_i);
    #1;
    n++;
  end
  if (!o_in_ready) begin
    report_timeout("o_in_ready");
  end else begin
    k = oldest(id, 1'b1);
    if (k < 0) begin
      errors++;
      $display("Input accepted for id %0d with no open slot at %0t ns", id, $time);
    end else begin
      e         = pend[k];
      e.filled  = 1'b1;
      e.payload = payload;
      pend[k]   = e;
    end
  end
  @(negedge clk_i);
  i_in_valid = 1'b0;
endtask

task automatic wait_out();
  int n;
  n = 0;
  #1;
  while (!o_out_valid && n < WAIT_LIMIT) begin
    @(negedge clk_i);
    #1;
    n++;
  end
  if (!o_out_valid) begin
    report_timeout("o_out_valid");
  end
endtask

// Expect the oldest response of exp_id, then complete the handshake
task automatic take_out(input axi_id_t exp_id);
  int k;
  wait_out();
  if (o_out_valid) begin
    check_val("o_out_data.id", int'(o_out_data.id), int'(exp_id));
    k = oldest(exp_id, 1'b0);
    if (k < 0 || !pend[k].filled) begin
      errors++;
      $display("Output for id %0d while no filled response waits at %0t ns", exp_id, $time);
    end else begin
      check_val("o_out_data.payload", int'(o_out_data.payload), int'(pend[k].payload));
      occ_model[pend[k].slot] = 1'b0;
      pend.delete(k);
    end
  end
  @(negedge clk_i);
  i_out_ready = 1'b1;
  @(negedge clk_i);
  i_out_ready = 1'b0;
endtask

//////////////////////////////
// Tests
//////////////////////////////

task automatic after_reset();
  check_val("o_rsv_ready", int'(o_rsv_ready), 1);
  check_val("o_out_valid", int'(o_out_valid), 0);
  check_val("o_in_ready", int'(o_in_ready), 0);
  // Id 3 holds no reservation, so input must be refused
  i_in_valid        = 1'b1;
  i_in_data.id      = 2'd3;
  i_in_data.payload = 2'd1;
  #1;
  check_val("o_in_ready", int'(o_in_ready), 0);
  @(negedge clk_i);
  i_in_valid = 1'b0;
endtask

task automatic sequential_alloc();
  slot_addr_t slot;
  for (int k = 0; k < `BANK_CAPACITY; k++) begin
    reserve(axi_id_t'(k % `BANK_NUM_IDS), slot);
    check_val("o_rsv_addr", int'(slot), k);
  end
  i_release_en = '1;
  #1;
  check_val("o_rsv_ready", int'(o_rsv_ready), 0);
  @(negedge clk_i);
  // Fill in slot order, id 0 loads first and stays lowest while it has more
  for (int k = 0; k < `BANK_CAPACITY; k++) begin
    send_resp(axi_id_t'(k % `BANK_NUM_IDS), wresp_payload_t'($urandom));
  end
  for (int k = 0; k < `BANK_CAPACITY; k++) begin
    take_out(axi_id_t'(k / 2));
  end
endtask

task automatic in_order_release();
  slot_addr_t slot;
  i_release_en = '1;
  reserve(2'd2, slot);
  reserve(2'd1, slot);
  reserve(2'd2, slot);
  reserve(2'd1, slot);
  reserve(2'd2, slot);
  // Distinct payloads per id expose any reordering
  send_resp(2'd2, 2'd0);
  send_resp(2'd2, 2'd1);
  send_resp(2'd2, 2'd2);
  send_resp(2'd1, 2'd3);
  send_resp(2'd1, 2'd2);
  // First id 2 response was already registered, then id 1 wins
  take_out(2'd2);
  take_out(2'd1);
  take_out(2'd1);
  take_out(2'd2);
  take_out(2'd2);
endtask

task automatic gated_release();
  slot_addr_t s3;
  slot_addr_t s0;
  slot_addr_t s1;
  i_release_en = '0;
  reserve(2'd3, s3);
  reserve(2'd0, s0);
  reserve(2'd1, s1);
  send_resp(2'd3, wresp_payload_t'($urandom));
  send_resp(2'd0, wresp_payload_t'($urandom));
  send_resp(2'd1, wresp_payload_t'($urandom));
  // All filled but nothing enabled
  for (int k = 0; k < 4; k++) begin
    #1;
    check_val("o_out_valid", int'(o_out_valid), 0);
    @(negedge clk_i);
  end
  i_release_en[s3] = 1'b1;
  take_out(2'd3);
  // Two eligible at once, lower id first
  i_release_en[s0] = 1'b1;
  i_release_en[s1] = 1'b1;
  take_out(2'd0);
  take_out(2'd1);
endtask

task automatic stall_hold();
  slot_addr_t slot;
  wresp_t     held;
  i_release_en = '1;
  reserve(2'd1, slot);
  reserve(2'd0, slot);
  send_resp(2'd1, wresp_payload_t'($urandom));
  wait_out();
  held = o_out_data;
  @(negedge clk_i);
  // Lower id fills behind the stalled response and must not replace it
  send_resp(2'd0, wresp_payload_t'($urandom));
  // Ready stays low, response must hold
  for (int k = 0; k < 6; k++) begin
    @(negedge clk_i);
    #1;
    check_val("o_out_valid", int'(o_out_valid), 1);
    check_val("o_out_data", int'(o_out_data), int'(held));
  end
  @(negedge clk_i);
  take_out(2'd1);
  take_out(2'd0);
endtask

task automatic slot_reuse();
  slot_addr_t s;
  slot_addr_t freed;
  i_release_en = '0;
  reserve(2'd1, s);
  reserve(2'd1, s);
  reserve(2'd1, s);
  reserve(2'd2, freed);
  send_resp(2'd2, wresp_payload_t'($urandom));
  i_release_en[freed] = 1'b1;
  take_out(2'd2);
  // Lower slots still belong to id 1, the freed one comes back first
  reserve(2'd0, s);
  check_val("o_rsv_addr", int'(s), int'(freed));
  send_resp(2'd1, wresp_payload_t'($urandom));
  send_resp(2'd1, wresp_payload_t'($urandom));
  send_resp(2'd1, wresp_payload_t'($urandom));
  send_resp(2'd0, wresp_payload_t'($urandom));
  i_release_en = '1;
  take_out(2'd0);
  take_out(2'd1);
  take_out(2'd1);
  take_out(2'd1);
endtask

`endif

// File: bench/resp_bank_tb.sv
// Testbench top for the write-response bank
// Clock, reset, DUT, reference model of pending responses and error counters

`timescale 1ns/1ps
`default_nettype none

`include "bank_cfg.svh"

module resp_bank_tb import resp_pkg::*, bank_pkg::*; ();

  logic                      clk_i;
  logic                      rst_ni;
  logic                      i_rsv_valid;
  logic [`BANK_NUM_IDS-1:0]  i_rsv_id_onehot;
  logic                      o_rsv_ready;
  slot_addr_t                o_rsv_addr;
  logic                      i_in_valid;
  wresp_t                    i_in_data;
  logic                      o_in_ready;
  logic [`BANK_CAPACITY-1:0] i_release_en;
  logic                      i_out_ready;
  logic                      o_out_valid;
  wresp_t                    o_out_data;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // One reserved slot as the model sees it
  typedef struct packed {
    axi_id_t        id;
    slot_addr_t     slot;
    logic           filled;
    wresp_payload_t payload;
  } entry_t;

  // Reservation order, so the first match of an id is its oldest slot
  entry_t                    pend[$];
  // Slots held between reservation and output handshake
  logic [`BANK_CAPACITY-1:0] occ_model;
  int                        errors;
  int                        checks;

  resp_bank i_dut (
    .clk_i,
    .rst_ni,
    .i_rsv_valid,
    .i_rsv_id_onehot,
    .o_rsv_ready,
    .o_rsv_addr,
    .i_in_valid,
    .i_in_data,
    .o_in_ready,
    .i_release_en,
    .i_out_ready,
    .o_out_valid,
    .o_out_data
  );

  // 40 ns period
  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  `include "resp_bank_tests.svh"

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    void'($urandom(32'h1d10a74b));
    errors          = 0;
    checks          = 0;
    occ_model       = '0;
    rst_ni          = 1'b0;
    i_rsv_valid     = 1'b0;
    i_rsv_id_onehot = '0;
    i_in_valid      = 1'b0;
    i_in_data       = '0;
    i_release_en    = '0;
    i_out_ready     = 1'b0;

    // Five clock cycles in reset
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    after_reset();
    sequential_alloc();
    in_order_release();
    gated_release();
    stall_hold();
    slot_reuse();

    // Every reserved slot should have left by now
    check_val("model entries left", pend.size(), 0);

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+hw
+incdir+bench
hw/resp_pkg.sv
hw/bank_pkg.sv
hw/slot_alloc.sv
hw/id_queue.sv
hw/msg_store.sv
hw/release_arb.sv
hw/resp_bank.sv
bench/resp_bank_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the bank testbench with Verilator, run it and scan the log for the verdict
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module resp_bank_tb \
  -f filelist.f \
  -o sim_resp_bank

./obj_dir/sim_resp_bank | tee sim.log

if grep -qxF '** PASS **' sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
